// File: Bender.yml
package:
  name: io_subsystem

sources:
  - design/io_pkg.sv
  - design/io_decode.sv
  - design/ps2_rx.sv
  - design/tone_gen.sv
  - design/io_subsystem.sv
  - target: test
    files:
      - testbench/io_checker.sv
      - testbench/tb_io_subsystem.sv

// File: all.f
design/io_pkg.sv
design/io_decode.sv
design/ps2_rx.sv
design/tone_gen.sv
design/io_subsystem.sv
testbench/io_checker.sv
testbench/tb_io_subsystem.sv

// File: design/io_decode.sv
`timescale 1ns/10ps

module io_decode
    import io_pkg::*;
(
    input  logic                  clock,
    input  logic                  rst,
    input  logic [addr_msb:2]     address,
    input  logic [data_width-1:0] wdata,
    input  logic [3:0]            strobes,
    input  logic                  read,
    input  logic                  write,
    input  logic [7:0]            scancode,
    input  logic                  parity_error,
    input  logic                  frame_done,
    output logic [data_width-1:0] rdata,
    output logic                  bus_error,
    output logic [2:0]            leds,
    output logic                  tone_duration_sel,
    output logic                  tone_period_sel
);

    logic [7:0]  high_byte;
    logic [7:0]  low_byte;
    reg_select_t sel;
    logic        scancode_ready;

    assign high_byte = address[addr_msb -: 8];
    assign low_byte  = {address[7:2], 2'b00};

    always_comb begin
        sel = sel_none;
        if (high_byte == io_region) begin
            case (low_byte)
                off_led:           sel = sel_led;
                off_ps2_status:    sel = sel_ps2_status;
                off_ps2_scancode:  sel = sel_ps2_scancode;
                off_tone_duration: sel = sel_tone_duration;
                off_tone_period:   sel = sel_tone_period;
                default:           sel = sel_none;
            endcase
        end
    end

    // Unused offsets and addresses outside the region both fault
    assign bus_error = (read || write) && (sel == sel_none);

    assign tone_duration_sel = (sel == sel_tone_duration);
    assign tone_period_sel   = (sel == sel_tone_period);

    // Tone registers are write only and read back as zero
    always_comb begin
        rdata = '0;
        case (sel)
            sel_led: begin
                rdata[2:0] = leds;
            end
            sel_ps2_status: begin
                rdata[data_width-1 -: 2] = {scancode_ready, parity_error};
            end
            sel_ps2_scancode: begin
                rdata[data_width-1 -: 8] = scancode;
            end
            default: begin
                rdata = '0;
            end
        endcase
    end

    // Only the low byte lane carries the LED bits
    always_ff @(posedge clock) begin
        if (rst) begin
            leds <= 3'b000;
        end else if (write && (sel == sel_led) && strobes[0]) begin
            leds <= wdata[2:0];
        end
    end

    // A new frame wins over a clearing read in the same cycle
    always_ff @(posedge clock) begin
        if (rst) begin
            scancode_ready <= 1'b0;
        end else if (frame_done) begin
            scancode_ready <= 1'b1;
        end else if (read && (sel == sel_ps2_scancode)) begin
            scancode_ready <= 1'b0;
        end
    end

    // The CPU issues one access per cycle
    read_write_exclusive: assert property (
        @(posedge clock) disable iff (rst) !(read && write)
    );

endmodule

// File: design/io_pkg.sv
package io_pkg;

    // CPU bus widths
    localparam int data_width = 32;
    localparam int addr_msb = 31;

    // High address byte of the peripheral region
    localparam logic [7:0] io_region = 8'h02;

    // Register offsets within the region, as low address bytes
    localparam logic [7:0] off_led           = 8'h00;
    localparam logic [7:0] off_ps2_status    = 8'h04;
    localparam logic [7:0] off_ps2_scancode  = 8'h08;
    localparam logic [7:0] off_tone_duration = 8'h0c;
    localparam logic [7:0] off_tone_period   = 8'h10;

    // Start, eight data bits, parity and stop
    localparam int ps2_frame_bits = 11;

    typedef enum logic [2:0] {
        sel_none,
        sel_led,
        sel_ps2_status,
        sel_ps2_scancode,
        sel_tone_duration,
        sel_tone_period
    } reg_select_t;

endpackage

// File: design/io_subsystem.sv
`timescale 1ns/10ps

module io_subsystem
    import io_pkg::*;
#(
    parameter int duration_prescale = 16
) (
    input  logic                  clock,
    input  logic                  rst,
    input  logic [addr_msb:2]     address,
    input  logic [data_width-1:0] wdata,
    input  logic [3:0]            strobes,
    input  logic                  read,
    input  logic                  write,
    input  logic                  ps2_clock,
    input  logic                  ps2_data,
    output logic [data_width-1:0] rdata,
    output logic                  bus_error,
    output logic [2:0]            leds,
    output logic                  buzzer
);

    logic       tone_duration_sel;
    logic       tone_period_sel;
    logic [7:0] scancode;
    logic       parity_error;
    logic       frame_done;

    io_decode u_decode (
        .clock             (clock),
        .rst               (rst),
        .address           (address),
        .wdata             (wdata),
        .strobes           (strobes),
        .read              (read),
        .write             (write),
        .scancode          (scancode),
        .parity_error      (parity_error),
        .frame_done        (frame_done),
        .rdata             (rdata),
        .bus_error         (bus_error),
        .leds              (leds),
        .tone_duration_sel (tone_duration_sel),
        .tone_period_sel   (tone_period_sel)
    );

    ps2_rx u_ps2_rx (
        .clock        (clock),
        .rst          (rst),
        .ps2_clock    (ps2_clock),
        .ps2_data     (ps2_data),
        .scancode     (scancode),
        .parity_error (parity_error),
        .frame_done   (frame_done)
    );

    tone_gen #(
        .duration_prescale (duration_prescale)
    ) u_tone_gen (
        .clock             (clock),
        .rst               (rst),
        .write             (write),
        .tone_duration_sel (tone_duration_sel),
        .tone_period_sel   (tone_period_sel),
        .wdata             (wdata),
        .buzzer            (buzzer)
    );

endmodule

// File: design/ps2_rx.sv
`timescale 1ns/10ps

module ps2_rx
    import io_pkg::*;
(
    input  logic       clock,
    input  logic       rst,
    input  logic       ps2_clock,
    input  logic       ps2_data,
    output logic [7:0] scancode,
    output logic       parity_error,
    output logic       frame_done
);

    logic                      clock_meta;
    logic                      clock_sync;
    logic                      clock_prev;
    logic                      data_meta;
    logic                      data_sync;
    logic                      fall;
    logic                      sample;
    logic [3:0]                bit_count;
    logic [ps2_frame_bits-1:0] frame;
    logic [ps2_frame_bits-1:0] frame_next;
    logic                      last_bit;
    logic                      frame_ok;

    // Both lines idle high
    always_ff @(posedge clock) begin
        if (rst) begin
            clock_meta <= 1'b1;
            clock_sync <= 1'b1;
            clock_prev <= 1'b1;
            data_meta  <= 1'b1;
            data_sync  <= 1'b1;
        end else begin
            clock_meta <= ps2_clock;
            clock_sync <= clock_meta;
            clock_prev <= clock_sync;
            data_meta  <= ps2_data;
            data_sync  <= data_meta;
        end
    end

    assign fall = clock_prev & ~clock_sync;

    // Data is taken one cycle after the edge is seen
    always_ff @(posedge clock) begin
        if (rst) begin
            sample <= 1'b0;
        end else begin
            sample <= fall;
        end
    end

    // Bits arrive LSB first, so shift in from the top
    assign frame_next = {data_sync, frame[ps2_frame_bits-1:1]};
    assign last_bit   = (bit_count == 4'(ps2_frame_bits - 1));

    // Start bit low, stop bit high
    assign frame_ok = !frame_next[0] && frame_next[ps2_frame_bits-1];

    always_ff @(posedge clock) begin
        if (sample) begin
            frame <= frame_next;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            bit_count    <= 4'd0;
            scancode     <= 8'h00;
            parity_error <= 1'b0;
            frame_done   <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (sample) begin
                if ((bit_count == 4'd0) && data_sync) begin
                    // Not a start bit, keep waiting
                    bit_count <= 4'd0;
                end else if (last_bit) begin
                    bit_count <= 4'd0;
                    if (frame_ok) begin
                        scancode     <= frame_next[8:1];
                        // Odd parity expected over data plus parity bit
                        parity_error <= ~^frame_next[9:1];
                        frame_done   <= 1'b1;
                    end
                end else begin
                    bit_count <= bit_count + 4'd1;
                end
            end
        end
    end

    frame_done_single: assert property (
        @(posedge clock) disable iff (rst) frame_done |=> !frame_done
    );

endmodule

// File: design/tone_gen.sv
`timescale 1ns/10ps

module tone_gen
    import io_pkg::*;
#(
    parameter int duration_prescale = 16
) (
    input  logic                  clock,
    input  logic                  rst,
    input  logic                  write,
    input  logic                  tone_duration_sel,
    input  logic                  tone_period_sel,
    input  logic [data_width-1:0] wdata,
    output logic                  buzzer
);

    localparam int prescale_width = (duration_prescale > 1) ? $clog2(duration_prescale) : 1;
    localparam logic [prescale_width-1:0] prescale_last = prescale_width'(duration_prescale - 1);

    logic [15:0]               period;
    logic [15:0]               duration_count;
    logic [15:0]               half_count;
    logic [prescale_width-1:0] prescale_count;
    logic                      active;
    logic                      unit_tick;
    logic                      half_tick;

    assign active    = (duration_count != 16'd0);
    assign unit_tick = (prescale_count == prescale_last);
    // >= so that a shorter period written mid-tone still wraps
    assign half_tick = (half_count >= period - 16'd1);

    always_ff @(posedge clock) begin
        if (rst) begin
            period <= 16'd0;
        end else if (write && tone_period_sel) begin
            period <= wdata[15:0];
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            duration_count <= 16'd0;
            prescale_count <= '0;
            half_count     <= 16'd0;
            buzzer         <= 1'b0;
        end else if (write && tone_duration_sel) begin
            // Restart the tone from a low level
            duration_count <= wdata[15:0];
            prescale_count <= '0;
            half_count     <= 16'd0;
            buzzer         <= 1'b0;
        end else if (active) begin
            prescale_count <= unit_tick ? '0 : prescale_count + prescale_width'(1);
            if (unit_tick) begin
                duration_count <= duration_count - 16'd1;
            end
            if (unit_tick && (duration_count == 16'd1)) begin
                buzzer     <= 1'b0;
                half_count <= 16'd0;
            end else if (period == 16'd0) begin
                buzzer     <= 1'b0;
                half_count <= 16'd0;
            end else if (half_tick) begin
                buzzer     <= ~buzzer;
                half_count <= 16'd0;
            end else begin
                half_count <= half_count + 16'd1;
            end
        end else begin
            prescale_count <= '0;
            half_count     <= 16'd0;
            buzzer         <= 1'b0;
        end
    end

    silent_when_done: assert property (
        @(posedge clock) disable iff (rst) (duration_count == 16'd0) |-> !buzzer
    );

endmodule

// File: testbench/io_checker.sv
`timescale 1ns/10ps

module io_checker
    import io_pkg::*;
#(
    parameter int duration_prescale = 16
) (
    input logic                  clock,
    input logic                  rst,
    input logic [addr_msb:2]     address,
    input logic [data_width-1:0] wdata,
    input logic [3:0]            strobes,
    input logic                  read,
    input logic                  write,
    input logic [data_width-1:0] rdata,
    input logic                  bus_error,
    input logic [2:0]            leds,
    input logic                  buzzer,
    input logic                  frame_done
);

    string       test_name = "reset";
    int          error_count = 0;
    int          check_count = 0;
    logic [2:0]  led_model;
    logic        ready_model;
    logic        parity_model;
    logic [7:0]  scancode_model;
    logic [7:0]  pending_byte;
    logic        pending_bad;
    logic [15:0] period_model;
    logic [15:0] duration_model;
    int          tone_cycle;
    reg_select_t sel;

    task automatic set_test_name(input string name);
        test_name = name;
    endtask

    // Byte and parity fault of the frame that the driver is about to send
    task automatic expect_frame(input logic [7:0] value, input logic bad_parity);
        pending_byte = value;
        pending_bad  = bad_parity;
    endtask

    task automatic report_failure(input string what);
        error_count++;
        $display("Error in test %s: %s", test_name, what);
    endtask

    task automatic compare(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error: test %s, %s expected %h, actual %h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic print_summary();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
    endtask

    function automatic reg_select_t decode_select(input logic [addr_msb:2] a);
        if (a[addr_msb -: 8] != io_region) begin
            return sel_none;
        end
        case ({a[7:2], 2'b00})
            off_led:           return sel_led;
            off_ps2_status:    return sel_ps2_status;
            off_ps2_scancode:  return sel_ps2_scancode;
            off_tone_duration: return sel_tone_duration;
            off_tone_period:   return sel_tone_period;
            default:           return sel_none;
        endcase
    endfunction

    // Any access outside the region or at an unused offset faults
    function automatic logic expected_bus_error(input logic [addr_msb:2] a, input logic rd,
                                                input logic wr);
        logic [7:0] low;
        logic       known;
        low   = {a[7:2], 2'b00};
        known = (low == off_led) || (low == off_ps2_status) || (low == off_ps2_scancode)
            || (low == off_tone_duration) || (low == off_tone_period);
        return (rd || wr) && ((a[addr_msb -: 8] != io_region) || !known);
    endfunction

    function automatic logic [31:0] expected_rdata(input reg_select_t s);
        case (s)
            sel_led:          return {29'd0, led_model};
            sel_ps2_status:   return {ready_model, parity_model, 30'd0};
            sel_ps2_scancode: return {scancode_model, 24'd0};
            default:          return 32'd0;
        endcase
    endfunction

    // Parity bit that gives the nine bits an odd weight
    function automatic logic odd_parity(input logic [7:0] value);
        return ~^value;
    endfunction

    function automatic int tone_length(input int duration);
        return duration * duration_prescale;
    endfunction

    // Square wave counted from the duration write edge
    function automatic logic expected_buzzer(input int cycle);
        if (period_model == 16'd0 || cycle == 0 || cycle >= tone_length(duration_model)) begin
            return 1'b0;
        end
        return ((cycle / period_model) % 2) == 1;
    endfunction

    assign sel = decode_select(address);

    always @(posedge clock) begin
        if (rst) begin
            led_model      <= 3'b000;
            ready_model    <= 1'b0;
            parity_model   <= 1'b0;
            scancode_model <= 8'h00;
            period_model   <= 16'd0;
            duration_model <= 16'd0;
            tone_cycle     <= 0;
        end else begin
            if (write && (sel == sel_led) && strobes[0]) begin
                led_model <= wdata[2:0];
            end
            if (write && (sel == sel_tone_period)) begin
                period_model <= wdata[15:0];
            end
            if (write && (sel == sel_tone_duration)) begin
                duration_model <= wdata[15:0];
                tone_cycle     <= 0;
            end else begin
                tone_cycle <= tone_cycle + 1;
            end
            if (frame_done) begin
                ready_model    <= 1'b1;
                scancode_model <= pending_byte;
                parity_model   <= pending_bad;
            end else if (read && (sel == sel_ps2_scancode)) begin
                ready_model <= 1'b0;
            end
        end
    end

    // Registered and combinational outputs have settled by the falling edge
    always @(negedge clock) begin
        if (!rst) begin
            compare("leds", led_model, leds);
            compare("buzzer", expected_buzzer(tone_cycle), buzzer);
            compare("bus_error", expected_bus_error(address, read, write), bus_error);
            if (read) begin
                compare("rdata", expected_rdata(sel), rdata);
            end
        end
    end

endmodule

// File: testbench/tb_io_subsystem.sv
`timescale 1ns/10ps

module tb_io_subsystem
    import io_pkg::*;
();

    localparam int clock_period = 40;
    localparam int prescale = 16;
    localparam int reset_cycles = 16;
    localparam int half_bit = 20;
    localparam int led_tests = 20;
    localparam int decode_tests = 40;
    localparam int good_frames = 6;
    localparam int bad_frames = 3;
    localparam int tone_tests = 6;
    localparam int frame_cycles = 11 * 2 * half_bit + 16;
    localparam int budget_cycles = 2 * (reset_cycles + led_tests * 4 + decode_tests * 4
        + (good_frames + bad_frames) * frame_cycles + (tone_tests + 1) * (8 * prescale + 8));

    logic                  clock;
    logic                  rst;
    logic [addr_msb:2]     address;
    logic [data_width-1:0] wdata;
    logic [3:0]            strobes;
    logic                  read;
    logic                  write;
    logic                  ps2_clock;
    logic                  ps2_data;
    logic [data_width-1:0] rdata;
    logic                  bus_error;
    logic [2:0]            leds;
    logic                  buzzer;
    logic                  frame_seen;
    int unsigned           seed;

    always #(clock_period / 2) clock = ~clock;

    io_subsystem #(
        .duration_prescale (prescale)
    ) DUT (
        .clock     (clock),
        .rst       (rst),
        .address   (address),
        .wdata     (wdata),
        .strobes   (strobes),
        .read      (read),
        .write     (write),
        .ps2_clock (ps2_clock),
        .ps2_data  (ps2_data),
        .rdata     (rdata),
        .bus_error (bus_error),
        .leds      (leds),
        .buzzer    (buzzer)
    );

    // The receiver handshake is internal to the DUT
    assign frame_seen = DUT.frame_done;

    io_checker #(
        .duration_prescale (prescale)
    ) u_checker (
        .clock      (clock),
        .rst        (rst),
        .address    (address),
        .wdata      (wdata),
        .strobes    (strobes),
        .read       (read),
        .write      (write),
        .rdata      (rdata),
        .bus_error  (bus_error),
        .leds       (leds),
        .buzzer     (buzzer),
        .frame_done (frame_seen)
    );

    function automatic logic [31:0] io_address(input logic [7:0] offset);
        return {io_region, 16'h0000, offset};
    endfunction

    task automatic bus_write(input logic [31:0] byte_address, input logic [31:0] data,
                             input logic [3:0] strb);
        address <= byte_address[31:2];
        wdata   <= data;
        strobes <= strb;
        write   <= 1'b1;
        @(posedge clock);
        write <= 1'b0;
    endtask

    task automatic bus_read(input logic [31:0] byte_address);
        address <= byte_address[31:2];
        read    <= 1'b1;
        @(posedge clock);
        read <= 1'b0;
    endtask

    task automatic probe_address(input int kind);
        logic [31:0] byte_address;
        case (kind)
            0:       byte_address = {io_region, 16'($urandom), 8'($urandom_range(4, 0) * 4)};
            1:       byte_address = {io_region, 16'($urandom), 6'($urandom), 2'b00};
            default: byte_address = $urandom;
        endcase
        // Writes go only outside the region and change no register
        if (byte_address[31:24] != io_region) begin
            bus_write(byte_address, $urandom, 4'hf);
        end
        bus_read(byte_address);
    endtask

    // Start, eight data bits LSB first, parity, stop
    task automatic send_frame(input logic [7:0] value, input logic bad_parity);
        logic [10:0] bits;
        logic        seen;
        int          i;
        bits = {1'b1, u_checker.odd_parity(value) ^ bad_parity, value, 1'b0};
        seen = 1'b0;
        u_checker.expect_frame(value, bad_parity);
        for (i = 0; i < 11; i++) begin
            ps2_data <= bits[i];
            repeat (half_bit) @(posedge clock);
            ps2_clock <= 1'b0;
            repeat (half_bit) begin
                @(posedge clock);
                if (frame_seen) begin
                    seen = 1'b1;
                end
            end
            ps2_clock <= 1'b1;
        end
        if (!seen) begin
            u_checker.report_failure("no frame_done came after a complete PS/2 frame");
        end
    endtask

    task automatic read_ps2_registers();
        bus_read(io_address(off_ps2_status));
        bus_read(io_address(off_ps2_scancode));
        bus_read(io_address(off_ps2_status));
    endtask

    task automatic play_tone(input int period, input int duration);
        bus_write(io_address(off_tone_period), period, 4'hf);
        bus_write(io_address(off_tone_duration), duration, 4'hf);
        repeat (u_checker.tone_length(duration) + 4) @(posedge clock);
    endtask

    initial begin
        seed = 32'hae80_93e5;
        void'($urandom(seed));
        clock     = 1'b0;
        rst       = 1'b1;
        address   = '0;
        wdata     = '0;
        strobes   = 4'h0;
        read      = 1'b0;
        write     = 1'b0;
        ps2_clock = 1'b1;
        ps2_data  = 1'b1;
        repeat (reset_cycles) @(posedge clock);
        rst <= 1'b0;

        u_checker.set_test_name("led_write");
        repeat (led_tests) begin
            bus_write(io_address(off_led), $urandom, 4'($urandom));
            bus_read(io_address(off_led));
        end

        u_checker.set_test_name("decode");
        repeat (decode_tests) begin
            probe_address($urandom_range(2, 0));
        end

        u_checker.set_test_name("ps2_receive");
        repeat (good_frames) begin
            send_frame(8'($urandom), 1'b0);
            read_ps2_registers();
        end

        u_checker.set_test_name("ps2_parity");
        repeat (bad_frames) begin
            send_frame(8'($urandom), 1'b1);
            read_ps2_registers();
        end

        u_checker.set_test_name("tone");
        repeat (tone_tests) begin
            play_tone($urandom_range(20, 2), $urandom_range(8, 1));
        end
        u_checker.set_test_name("tone_silent");
        play_tone(0, $urandom_range(8, 1));

        repeat (4) @(posedge clock);
        u_checker.print_summary();
        if (u_checker.error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(budget_cycles * clock_period);
        $display("Timeout: the run did not finish within %0d clock cycles", budget_cycles);
        u_checker.print_summary();
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule
